// File: filelist.f
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/instrDecoder.sv
logic/controlSequencer.sv
logic/controlWordGen.sv
logic/controlUnit.sv
tb/controlUnit_sva.sv
tb/controlUnitTb.sv

// File: logic/controlSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module controlSequencer (
    input  logic               clk,
    input  logic               reset,
    input  ctrlPkg::instClassT instClass,
    output ctrlPkg::stateT     state,
    output ctrlPkg::instClassT activeClass,
    output logic               lastStep
);

    import ctrlPkg::*;

    logic [STEP_WIDTH-1:0] step;
    stateT                 nextState;

    // Final cycle of the current phase
    always_comb begin
        case (state)
            ST_FETCH: lastStep = (step == STEP_WIDTH'(FETCH_CYCLES - 1));
            ST_MEM: begin
                if (activeClass == CLS_LW) begin
                    lastStep = (step == STEP_WIDTH'(MEM_READ_CYCLES - 1));
                end else begin
                    lastStep = 1'b1;
                end
            end
            default: lastStep = 1'b1;
        endcase
    end

    // Phase order after the current one ends
    always_comb begin
        nextState = ST_FETCH;
        case (state)
            ST_FETCH: nextState = ST_DECODE;
            // Class is not latched yet, so decode looks at the decoder directly
            ST_DECODE: nextState = (instClass == CLS_NOP) ? ST_FETCH : ST_EXEC;
            ST_EXEC: begin
                case (activeClass)
                    CLS_ADD, CLS_SUB, CLS_AND, CLS_SLT, CLS_ADDI: nextState = ST_WB;
                    CLS_LW, CLS_SW: nextState = ST_MEM;
                    default: nextState = ST_FETCH;
                endcase
            end
            ST_MEM: nextState = (activeClass == CLS_LW) ? ST_WB : ST_FETCH;
            default: nextState = ST_FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // Park in a write-back of a no-op, which drives no strobes
            state       <= ST_WB;
            step        <= '0;
            activeClass <= CLS_NOP;
        end else begin
            if (lastStep) begin
                state <= nextState;
                step  <= '0;
            end else begin
                step <= step + 1'b1;
            end
            if (state == ST_DECODE) begin
                activeClass <= instClass;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  logic              clk,
    input  logic              reset,
    input  isaPkg::opcodeT    opcode,
    input  isaPkg::functT     funct,
    output logic              pcWrite,
    output logic              pcWriteCondBeq,
    output logic              pcWriteCondBne,
    output logic              memRead,
    output logic              memWrite,
    output logic              irWrite,
    output logic              regWrite,
    output logic              regAWrite,
    output logic              regBWrite,
    output logic              aluOutWrite,
    output logic              mdrWrite,
    output ctrlPkg::aluOpT    aluOp,
    output ctrlPkg::aluSrcAT  aluSrcA,
    output ctrlPkg::aluSrcBT  aluSrcB,
    output ctrlPkg::iorDT     iorD,
    output ctrlPkg::regDstT   regDst,
    output ctrlPkg::memToRegT memToReg,
    output ctrlPkg::pcSourceT pcSource
);

    import ctrlPkg::*;

    instClassT instClass;
    instClassT activeClass;
    stateT     state;
    logic      lastStep;

    instrDecoder u_decoder (
        .opcode    (opcode),
        .funct     (funct),
        .instClass (instClass)
    );

    controlSequencer u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .instClass   (instClass),
        .state       (state),
        .activeClass (activeClass),
        .lastStep    (lastStep)
    );

    controlWordGen u_wordGen (
        .state          (state),
        .activeClass    (activeClass),
        .lastStep       (lastStep),
        .pcWrite        (pcWrite),
        .pcWriteCondBeq (pcWriteCondBeq),
        .pcWriteCondBne (pcWriteCondBne),
        .memRead        (memRead),
        .memWrite       (memWrite),
        .irWrite        (irWrite),
        .regWrite       (regWrite),
        .regAWrite      (regAWrite),
        .regBWrite      (regBWrite),
        .aluOutWrite    (aluOutWrite),
        .mdrWrite       (mdrWrite),
        .aluOp          (aluOp),
        .aluSrcA        (aluSrcA),
        .aluSrcB        (aluSrcB),
        .iorD           (iorD),
        .regDst         (regDst),
        .memToReg       (memToReg),
        .pcSource       (pcSource)
    );

endmodule

`default_nettype wire

// File: logic/controlWordGen.sv
`timescale 1ns/1ps
`default_nettype none

module controlWordGen (
    input  ctrlPkg::stateT     state,
    input  ctrlPkg::instClassT activeClass,
    input  logic               lastStep,
    output logic               pcWrite,
    output logic               pcWriteCondBeq,
    output logic               pcWriteCondBne,
    output logic               memRead,
    output logic               memWrite,
    output logic               irWrite,
    output logic               regWrite,
    output logic               regAWrite,
    output logic               regBWrite,
    output logic               aluOutWrite,
    output logic               mdrWrite,
    output ctrlPkg::aluOpT     aluOp,
    output ctrlPkg::aluSrcAT   aluSrcA,
    output ctrlPkg::aluSrcBT   aluSrcB,
    output ctrlPkg::iorDT      iorD,
    output ctrlPkg::regDstT    regDst,
    output ctrlPkg::memToRegT  memToReg,
    output ctrlPkg::pcSourceT  pcSource
);

    import ctrlPkg::*;

    always_comb begin
        // Everything idle unless a phase asks for it
        pcWrite        = 1'b0;
        pcWriteCondBeq = 1'b0;
        pcWriteCondBne = 1'b0;
        memRead        = 1'b0;
        memWrite       = 1'b0;
        irWrite        = 1'b0;
        regWrite       = 1'b0;
        regAWrite      = 1'b0;
        regBWrite      = 1'b0;
        aluOutWrite    = 1'b0;
        mdrWrite       = 1'b0;
        aluOp          = ALU_ADD;
        aluSrcA        = SRCA_PC;
        aluSrcB        = SRCB_REGB;
        iorD           = ADDR_PC;
        regDst         = DST_RT;
        memToReg       = WB_ALUOUT;
        pcSource       = PCSRC_ALU;

        case (state)
            ST_FETCH: begin
                memRead = 1'b1;
                iorD    = ADDR_PC;
                // Word arrives on the last read cycle, PC+4 goes in together
                if (lastStep) begin
                    irWrite  = 1'b1;
                    pcWrite  = 1'b1;
                    aluSrcA  = SRCA_PC;
                    aluSrcB  = SRCB_FOUR;
                    aluOp    = ALU_ADD;
                    pcSource = PCSRC_ALU;
                end
            end
            ST_DECODE: begin
                regAWrite   = 1'b1;
                regBWrite   = 1'b1;
                // Branch target into ALUOut
                aluOutWrite = 1'b1;
                aluSrcA     = SRCA_PC;
                aluSrcB     = SRCB_IMM_SHIFTED;
                aluOp       = ALU_ADD;
            end
            ST_EXEC: begin
                aluSrcA = SRCA_REGA;
                case (activeClass)
                    CLS_ADD, CLS_SUB, CLS_AND, CLS_SLT: begin
                        aluSrcB     = SRCB_REGB;
                        aluOutWrite = 1'b1;
                        case (activeClass)
                            CLS_SUB: aluOp = ALU_SUB;
                            CLS_AND: aluOp = ALU_AND;
                            CLS_SLT: aluOp = ALU_SLT;
                            default: aluOp = ALU_ADD;
                        endcase
                    end
                    // ADDI result and load/store address share this path
                    CLS_ADDI, CLS_LW, CLS_SW: begin
                        aluSrcB     = SRCB_IMM;
                        aluOp       = ALU_ADD;
                        aluOutWrite = 1'b1;
                    end
                    CLS_BEQ, CLS_BNE: begin
                        aluSrcB        = SRCB_REGB;
                        aluOp          = ALU_SUB;
                        pcSource       = PCSRC_ALUOUT;
                        pcWriteCondBeq = (activeClass == CLS_BEQ);
                        pcWriteCondBne = (activeClass == CLS_BNE);
                    end
                    CLS_J: begin
                        pcWrite  = 1'b1;
                        pcSource = PCSRC_JUMP;
                    end
                    default: ;
                endcase
            end
            ST_MEM: begin
                iorD = ADDR_ALUOUT;
                if (activeClass == CLS_LW) begin
                    memRead  = 1'b1;
                    mdrWrite = lastStep;
                end else if (activeClass == CLS_SW) begin
                    memWrite = 1'b1;
                end
            end
            ST_WB: begin
                case (activeClass)
                    CLS_ADD, CLS_SUB, CLS_AND, CLS_SLT: begin
                        regWrite = 1'b1;
                        regDst   = DST_RD;
                        memToReg = WB_ALUOUT;
                    end
                    CLS_ADDI: begin
                        regWrite = 1'b1;
                        regDst   = DST_RT;
                        memToReg = WB_ALUOUT;
                    end
                    CLS_LW: begin
                        regWrite = 1'b1;
                        regDst   = DST_RT;
                        memToReg = WB_MDR;
                    end
                    // No-op here is the reset parking slot
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    // Phase lengths in cycles
    localparam int FETCH_CYCLES    = 3;
    localparam int MEM_READ_CYCLES = 3;
    localparam int STEP_WIDTH      = 2;

    // Instruction classes seen by the sequencer
    typedef enum logic [3:0] {
        CLS_ADD,
        CLS_SUB,
        CLS_AND,
        CLS_SLT,
        CLS_ADDI,
        CLS_LW,
        CLS_SW,
        CLS_BEQ,
        CLS_BNE,
        CLS_J,
        CLS_NOP
    } instClassT;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXEC,
        ST_MEM,
        ST_WB
    } stateT;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_SLT} aluOpT;

    // Datapath mux selects
    typedef enum logic {SRCA_PC, SRCA_REGA} aluSrcAT;

    typedef enum logic [1:0] {
        SRCB_REGB,
        SRCB_FOUR,
        SRCB_IMM,
        SRCB_IMM_SHIFTED
    } aluSrcBT;

    typedef enum logic {ADDR_PC, ADDR_ALUOUT} iorDT;
    typedef enum logic {DST_RT, DST_RD} regDstT;
    typedef enum logic {WB_ALUOUT, WB_MDR} memToRegT;

    typedef enum logic [1:0] {PCSRC_ALU, PCSRC_ALUOUT, PCSRC_JUMP} pcSourceT;

endpackage

`default_nettype wire

// File: logic/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  isaPkg::opcodeT     opcode,
    input  isaPkg::functT      funct,
    output ctrlPkg::instClassT instClass
);

    import isaPkg::*;
    import ctrlPkg::*;

    always_comb begin
        instClass = CLS_NOP;
        case (opcode)
            OP_RTYPE: begin
                // R-type is resolved by funct
                case (funct)
                    FN_ADD:  instClass = CLS_ADD;
                    FN_SUB:  instClass = CLS_SUB;
                    FN_AND:  instClass = CLS_AND;
                    FN_SLT:  instClass = CLS_SLT;
                    default: instClass = CLS_NOP;
                endcase
            end
            OP_ADDI: instClass = CLS_ADDI;
            OP_LW:   instClass = CLS_LW;
            OP_SW:   instClass = CLS_SW;
            OP_BEQ:  instClass = CLS_BEQ;
            OP_BNE:  instClass = CLS_BNE;
            OP_J:    instClass = CLS_J;
            // Unsupported opcodes fall through as no-ops
            default: instClass = CLS_NOP;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/isaPkg.sv
`default_nettype none

package isaPkg;

    // Instruction field widths
    localparam int OPCODE_WIDTH = 6;
    localparam int FUNCT_WIDTH  = 6;

    // Primary opcodes kept in this core
    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcodeT;

    // Funct codes of the R-type ALU instructions
    typedef enum logic [FUNCT_WIDTH-1:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_SLT = 6'h2a
    } functT;

endpackage

`default_nettype wire

// File: tb/controlUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb;

    import isaPkg::*;
    import ctrlPkg::*;

    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = 50;
    localparam int NUM_ROWS       = 12;

    logic      clk;
    logic      reset;
    opcodeT    opcode;
    functT     funct;
    logic      pcWrite;
    logic      pcWriteCondBeq;
    logic      pcWriteCondBne;
    logic      memRead;
    logic      memWrite;
    logic      irWrite;
    logic      regWrite;
    logic      regAWrite;
    logic      regBWrite;
    logic      aluOutWrite;
    logic      mdrWrite;
    aluOpT     aluOp;
    aluSrcAT   aluSrcA;
    aluSrcBT   aluSrcB;
    iorDT      iorD;
    regDstT    regDst;
    memToRegT  memToReg;
    pcSourceT  pcSource;

    // Instruction table, one entry per instruction
    string    rowName    [NUM_ROWS];
    opcodeT   rowOpcode  [NUM_ROWS];
    functT    rowFunct   [NUM_ROWS];
    int       rowPeriod  [NUM_ROWS];
    int       rowRegW    [NUM_ROWS];
    int       rowMemW    [NUM_ROWS];
    int       rowMemR    [NUM_ROWS];
    int       rowMdr     [NUM_ROWS];
    int       rowCondBeq [NUM_ROWS];
    int       rowCondBne [NUM_ROWS];
    int       rowPcW     [NUM_ROWS];
    int       rowHasExec [NUM_ROWS];
    aluOpT    rowAluOp   [NUM_ROWS];
    aluSrcBT  rowSrcB    [NUM_ROWS];
    regDstT   rowDst     [NUM_ROWS];
    memToRegT rowWbSrc   [NUM_ROWS];

    controlUnit u_dut (
        .clk            (clk),
        .reset          (reset),
        .opcode         (opcode),
        .funct          (funct),
        .pcWrite        (pcWrite),
        .pcWriteCondBeq (pcWriteCondBeq),
        .pcWriteCondBne (pcWriteCondBne),
        .memRead        (memRead),
        .memWrite       (memWrite),
        .irWrite        (irWrite),
        .regWrite       (regWrite),
        .regAWrite      (regAWrite),
        .regBWrite      (regBWrite),
        .aluOutWrite    (aluOutWrite),
        .mdrWrite       (mdrWrite),
        .aluOp          (aluOp),
        .aluSrcA        (aluSrcA),
        .aluSrcB        (aluSrcB),
        .iorD           (iorD),
        .regDst         (regDst),
        .memToReg       (memToReg),
        .pcSource       (pcSource)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkValue(input string testName, input int expected, input int actual);
        if (expected != actual) begin
            abortRun($sformatf("[FAIL] %s expected %0d actual %0d", testName, expected, actual));
        end
    endtask

    task automatic setRow(input int idx, input string name, input opcodeT op, input functT fn,
                          input int period, input int regW, input int memW, input int memR,
                          input int mdr, input int condBeq, input int condBne, input int pcW,
                          input int hasExec, input aluOpT execOp);
        rowName[idx]    = name;
        rowOpcode[idx]  = op;
        rowFunct[idx]   = fn;
        rowPeriod[idx]  = period;
        rowRegW[idx]    = regW;
        rowMemW[idx]    = memW;
        rowMemR[idx]    = memR;
        rowMdr[idx]     = mdr;
        rowCondBeq[idx] = condBeq;
        rowCondBne[idx] = condBne;
        rowPcW[idx]     = pcW;
        rowHasExec[idx] = hasExec;
        rowAluOp[idx]   = execOp;
    endtask

    task automatic setMuxRow(input int idx, input aluSrcBT srcB, input regDstT dst,
                             input memToRegT wbSrc);
        rowSrcB[idx]  = srcB;
        rowDst[idx]   = dst;
        rowWbSrc[idx] = wbSrc;
    endtask

    task automatic loadTable;
        // name, opcode, funct, period, regW, memW, memR, mdr, beq, bne, pcW, exec, aluOp
        setRow(0, "ADD", OP_RTYPE, FN_ADD, 6, 1, 0, 3, 0, 0, 0, 1, 1, ALU_ADD);
        setRow(1, "SUB", OP_RTYPE, FN_SUB, 6, 1, 0, 3, 0, 0, 0, 1, 1, ALU_SUB);
        setRow(2, "AND", OP_RTYPE, FN_AND, 6, 1, 0, 3, 0, 0, 0, 1, 1, ALU_AND);
        setRow(3, "SLT", OP_RTYPE, FN_SLT, 6, 1, 0, 3, 0, 0, 0, 1, 1, ALU_SLT);
        setRow(4, "ADDI", OP_ADDI, FN_ADD, 6, 1, 0, 3, 0, 0, 0, 1, 1, ALU_ADD);
        // Fetch reads plus three data reads
        setRow(5, "LW", OP_LW, FN_ADD, 9, 1, 0, 6, 1, 0, 0, 1, 1, ALU_ADD);
        setRow(6, "SW", OP_SW, FN_ADD, 6, 0, 1, 3, 0, 0, 0, 1, 1, ALU_ADD);
        setRow(7, "BEQ", OP_BEQ, FN_ADD, 5, 0, 0, 3, 0, 1, 0, 1, 1, ALU_SUB);
        setRow(8, "BNE", OP_BNE, FN_ADD, 5, 0, 0, 3, 0, 0, 1, 1, 1, ALU_SUB);
        // PC+4 in fetch, then the jump itself
        setRow(9, "J", OP_J, FN_ADD, 5, 0, 0, 3, 0, 0, 0, 2, 0, ALU_ADD);
        setRow(10, "BAD_FUNCT", OP_RTYPE, functT'(6'h25), 4, 0, 0, 3, 0, 0, 0, 1, 0, ALU_ADD);
        setRow(11, "BAD_OPCODE", opcodeT'(6'h0f), FN_ADD, 4, 0, 0, 3, 0, 0, 0, 1, 0, ALU_ADD);
        // Execute B source, then write-back destination and data source
        setMuxRow(0, SRCB_REGB, DST_RD, WB_ALUOUT);
        setMuxRow(1, SRCB_REGB, DST_RD, WB_ALUOUT);
        setMuxRow(2, SRCB_REGB, DST_RD, WB_ALUOUT);
        setMuxRow(3, SRCB_REGB, DST_RD, WB_ALUOUT);
        setMuxRow(4, SRCB_IMM, DST_RT, WB_ALUOUT);
        setMuxRow(5, SRCB_IMM, DST_RT, WB_MDR);
        setMuxRow(6, SRCB_IMM, DST_RT, WB_ALUOUT);
        setMuxRow(7, SRCB_REGB, DST_RT, WB_ALUOUT);
        setMuxRow(8, SRCB_REGB, DST_RT, WB_ALUOUT);
    endtask

    // Entered in the irWrite cycle of the row, returns in the next irWrite cycle
    task automatic measureInstruction(input int idx);
        int    cycles;
        int    nRegW;
        int    nMemW;
        int    nMemR;
        int    nMdr;
        int    nBeq;
        int    nBne;
        int    nPcW;
        int    nDecode;
        aluOpT execOp;
        opcode  = rowOpcode[idx];
        funct   = rowFunct[idx];
        cycles  = 0;
        nRegW   = 0;
        nMemW   = 0;
        nMemR   = 0;
        nMdr    = 0;
        nBeq    = 0;
        nBne    = 0;
        nPcW    = 0;
        nDecode = 0;
        execOp  = ALU_ADD;
        do begin
            if (cycles == TIMEOUT_CYCLES) begin
                abortRun($sformatf("%s: no irWrite pulse within %0d cycles",
                                   rowName[idx], TIMEOUT_CYCLES));
            end
            // Last fetch cycle computes PC+4
            if (cycles == 0) begin
                checkValue({rowName[idx], " fetch aluSrcA"}, int'(SRCA_PC), int'(aluSrcA));
                checkValue({rowName[idx], " fetch aluSrcB"}, int'(SRCB_FOUR), int'(aluSrcB));
            end
            if (cycles == 1) begin
                checkValue({rowName[idx], " decode aluSrcA"}, int'(SRCA_PC), int'(aluSrcA));
                checkValue({rowName[idx], " decode aluSrcB"}, int'(SRCB_IMM_SHIFTED),
                           int'(aluSrcB));
                checkValue({rowName[idx], " decode writes"}, 7,
                           int'({regAWrite, regBWrite, aluOutWrite}));
            end
            if (cycles == 2 && rowHasExec[idx] != 0) begin
                checkValue({rowName[idx], " exec aluSrcA"}, int'(SRCA_REGA), int'(aluSrcA));
                checkValue({rowName[idx], " exec aluSrcB"}, int'(rowSrcB[idx]),
                           int'(aluSrcB));
            end
            if (regWrite) begin
                checkValue({rowName[idx], " regDst"}, int'(rowDst[idx]), int'(regDst));
                checkValue({rowName[idx], " memToReg"}, int'(rowWbSrc[idx]), int'(memToReg));
            end
            // Outside fetch only the jump writes the PC
            if (pcWrite) begin
                checkValue({rowName[idx], " pcSource"},
                           (cycles == 0) ? int'(PCSRC_ALU) : int'(PCSRC_JUMP), int'(pcSource));
            end
            if (pcWriteCondBeq || pcWriteCondBne) begin
                checkValue({rowName[idx], " branch pcSource"}, int'(PCSRC_ALUOUT),
                           int'(pcSource));
            end
            // Fetch reads are cycle 0 and the last two cycles of the period
            if (memRead || memWrite) begin
                checkValue({rowName[idx], " iorD"},
                           (cycles == 0 || cycles >= rowPeriod[idx] - 2) ?
                           int'(ADDR_PC) : int'(ADDR_ALUOUT),
                           int'(iorD));
            end
            nRegW   += int'(regWrite);
            nMemW   += int'(memWrite);
            nMemR   += int'(memRead);
            nMdr    += int'(mdrWrite);
            nBeq    += int'(pcWriteCondBeq);
            nBne    += int'(pcWriteCondBne);
            nPcW    += int'(pcWrite);
            nDecode += int'(regAWrite);
            // Execute comes right after decode
            if (cycles == 2) begin
                execOp = aluOp;
            end
            cycles++;
            @(posedge clk);
            #1;
        end while (!irWrite);

        checkValue({rowName[idx], " period"}, rowPeriod[idx], cycles);
        checkValue({rowName[idx], " decode cycles"}, 1, nDecode);
        checkValue({rowName[idx], " regWrite"}, rowRegW[idx], nRegW);
        checkValue({rowName[idx], " memWrite"}, rowMemW[idx], nMemW);
        checkValue({rowName[idx], " memRead"}, rowMemR[idx], nMemR);
        checkValue({rowName[idx], " mdrWrite"}, rowMdr[idx], nMdr);
        checkValue({rowName[idx], " pcWriteCondBeq"}, rowCondBeq[idx], nBeq);
        checkValue({rowName[idx], " pcWriteCondBne"}, rowCondBne[idx], nBne);
        checkValue({rowName[idx], " pcWrite"}, rowPcW[idx], nPcW);
        if (rowHasExec[idx] != 0) begin
            checkValue({rowName[idx], " aluOp"}, int'(rowAluOp[idx]), int'(execOp));
        end
    endtask

    initial begin
        int waited;
        loadTable();
        reset  = 1'b1;
        opcode = rowOpcode[0];
        funct  = rowFunct[0];

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            #1;
            checkValue("reset strobes", 0,
                       int'({pcWrite, pcWriteCondBeq, pcWriteCondBne, memRead, memWrite,
                             irWrite, regWrite, regAWrite, regBWrite, aluOutWrite, mdrWrite}));
        end
        reset = 1'b0;

        // Three fetch cycles until the first instruction word lands
        waited = 0;
        do begin
            if (waited == TIMEOUT_CYCLES) begin
                abortRun("first irWrite pulse never arrived after reset");
            end
            @(posedge clk);
            #1;
            waited++;
        end while (!irWrite);
        checkValue("first fetch latency", 3, waited);

        for (int idx = 0; idx < NUM_ROWS; idx++) begin
            measureInstruction(idx);
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/controlUnit_sva.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnitProps (
    input logic clk,
    input logic reset,
    input logic pcWrite,
    input logic pcWriteCondBeq,
    input logic pcWriteCondBne,
    input logic memRead,
    input logic memWrite,
    input logic irWrite,
    input logic regWrite,
    input logic regAWrite,
    input logic regBWrite,
    input logic aluOutWrite,
    input logic mdrWrite
);

    logic [10:0] strobes;

    assign strobes = {pcWrite, pcWriteCondBeq, pcWriteCondBne, memRead, memWrite, irWrite,
                      regWrite, regAWrite, regBWrite, aluOutWrite, mdrWrite};

    // Single memory port
    assert property (@(posedge clk) disable iff (reset) !(memRead && memWrite))
        else $error("memRead and memWrite high together");

    assert property (@(posedge clk) disable iff (reset) irWrite |-> memRead)
        else $error("irWrite without memRead");

    assert property (@(posedge clk) disable iff (reset) !(pcWriteCondBeq && pcWriteCondBne))
        else $error("both conditional PC writes high");

    // Second reset cycle onward, once the state register is known
    assert property (@(posedge clk) (reset && $past(reset)) |-> (strobes == '0))
        else $error("strobe active during reset");

endmodule

bind controlUnit controlUnitProps u_props (
    .clk            (clk),
    .reset          (reset),
    .pcWrite        (pcWrite),
    .pcWriteCondBeq (pcWriteCondBeq),
    .pcWriteCondBne (pcWriteCondBne),
    .memRead        (memRead),
    .memWrite       (memWrite),
    .irWrite        (irWrite),
    .regWrite       (regWrite),
    .regAWrite      (regAWrite),
    .regBWrite      (regBWrite),
    .aluOutWrite    (aluOutWrite),
    .mdrWrite       (mdrWrite)
);

`default_nettype wire
